// File: common/rv_core_cfg.svh
// rv core configuration
// reset address, register count and machine CSR addresses
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

`define RV_RESET_ADDR    32'h0000_0000
`define RV_NUM_REGS      32
`define RV_CSR_MSTATUS   12'h300
`define RV_CSR_MTVEC     12'h305
`define RV_CSR_MSCRATCH  12'h340
`define RV_CSR_MEPC      12'h341

`endif

// File: common/rv_core_pkg.sv
// rv core package
// word and address types, opcode and funct3 encodings, ALU operations
package rv_core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        FENCE  = 7'b0001111,
        SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_e;

    typedef enum logic [2:0] {
        CSR_RW  = 3'b001,
        CSR_RS  = 3'b010,
        CSR_RC  = 3'b011,
        CSR_RWI = 3'b101,
        CSR_RSI = 3'b110,
        CSR_RCI = 3'b111
    } csr_op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

endpackage

// File: common/pipe_if.sv
// pipeline bundles
// id_ex_if carries decode results, wb_if carries register and CSR write-back
`timescale 1ns/1ps

interface id_ex_if;
    import rv_core_pkg::*;

    logic      valid;
    word_t     inst_addr;
    word_t     op1, op2, op1_jump, op2_jump;
    alu_op_e   alu_op;
    logic      is_branch, is_jump;
    branch_e   branch_op;
    logic      reg_we;
    reg_addr_t reg_waddr;
    logic      csr_we;
    csr_addr_t csr_waddr;
    word_t     csr_rdata, csr_src;
    csr_op_e   csr_op;

    modport dec (output valid, inst_addr, op1, op2, op1_jump, op2_jump, alu_op, is_branch,
                 branch_op, is_jump, reg_we, reg_waddr, csr_we, csr_waddr, csr_rdata,
                 csr_op, csr_src);
    modport exe (input valid, inst_addr, op1, op2, op1_jump, op2_jump, alu_op, is_branch,
                 branch_op, is_jump, reg_we, reg_waddr, csr_we, csr_waddr, csr_rdata,
                 csr_op, csr_src);
endinterface

interface wb_if;
    import rv_core_pkg::*;

    logic      reg_we, csr_we;
    reg_addr_t reg_waddr;
    word_t     reg_wdata, csr_wdata;
    csr_addr_t csr_waddr;

    modport src (output reg_we, reg_waddr, reg_wdata, csr_we, csr_waddr, csr_wdata);
    modport dst (input reg_we, reg_waddr, reg_wdata, csr_we, csr_waddr, csr_wdata);
endinterface

// File: decode/if_id.sv
// fetch to decode register
// holds the presented instruction for one cycle, empty slot on flush
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module if_id (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 flush_i,
    input  rv_core_pkg::inst_t   inst_i,
    input  rv_core_pkg::word_t   inst_addr_i,
    input  logic                 inst_valid_i,
    output rv_core_pkg::inst_t   inst_o,
    output rv_core_pkg::word_t   inst_addr_o,
    output logic                 valid_o
);
    import rv_core_pkg::*;

    localparam inst_t NOP_INST = 32'h0000_0013; // addi x0, x0, 0

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            valid_o     <= 1'b0;
            inst_o      <= NOP_INST;
            inst_addr_o <= `RV_RESET_ADDR;
        end else begin
            valid_o     <= inst_valid_i;
            inst_o      <= inst_valid_i ? inst_i : NOP_INST; // gaps decode as nop
            inst_addr_o <= inst_addr_i;
        end
    end

endmodule

// File: decode/id.sv
// instruction decode
// combinational: splits fields, reads registers and CSRs, selects
// ALU and jump operands and the write controls for execute
`timescale 1ns/1ps

module id (
    input  rv_core_pkg::inst_t      inst_i,
    input  rv_core_pkg::word_t      inst_addr_i,
    input  logic                    valid_i,
    output rv_core_pkg::reg_addr_t  reg1_raddr_o,
    output rv_core_pkg::reg_addr_t  reg2_raddr_o,
    input  rv_core_pkg::word_t      reg1_rdata_i,
    input  rv_core_pkg::word_t      reg2_rdata_i,
    output rv_core_pkg::csr_addr_t  csr_raddr_o,
    input  rv_core_pkg::word_t      csr_rdata_i,
    id_ex_if.dec                    dec
);
    import rv_core_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd, rs1, rs2;
    word_t      imm_i, imm_b, imm_j, imm_u;

    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd     = inst_i[11:7];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    // alt selects sub / sra
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_sel = alt ? ALU_SUB : ALU_ADD;
            3'b001:  alu_sel = ALU_SLL;
            3'b010:  alu_sel = ALU_SLT;
            3'b011:  alu_sel = ALU_SLTU;
            3'b100:  alu_sel = ALU_XOR;
            3'b101:  alu_sel = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    endfunction

    always_comb begin
        dec.valid     = valid_i;
        dec.inst_addr = inst_addr_i;
        dec.op1       = '0;
        dec.op2       = '0;
        dec.op1_jump  = '0;
        dec.op2_jump  = '0;
        dec.alu_op    = ALU_ADD;
        dec.is_branch = 1'b0;
        dec.is_jump   = 1'b0;
        dec.branch_op = branch_e'(funct3);
        dec.reg_we    = 1'b0;
        dec.reg_waddr = rd;
        dec.csr_we    = 1'b0;
        dec.csr_waddr = '0;
        dec.csr_rdata = csr_rdata_i;
        dec.csr_op    = csr_op_e'(funct3);
        dec.csr_src   = '0;
        reg1_raddr_o  = '0;
        reg2_raddr_o  = '0;
        csr_raddr_o   = '0;

        case (opcode_e'(inst_i[6:0]))
            OP_IMM: begin
                reg1_raddr_o = rs1;
                dec.reg_we   = 1'b1;
                dec.op1      = reg1_rdata_i;
                dec.op2      = imm_i;
                dec.alu_op   = alu_sel(funct3, inst_i[30] && funct3 == 3'b101);
            end
            OP: begin
                if (funct7 == 7'b0000000 || funct7 == 7'b0100000) begin // M ext has no effect
                    reg1_raddr_o = rs1;
                    reg2_raddr_o = rs2;
                    dec.reg_we   = 1'b1;
                    dec.op1      = reg1_rdata_i;
                    dec.op2      = reg2_rdata_i;
                    dec.alu_op   = alu_sel(funct3, inst_i[30]);
                end
            end
            BRANCH: begin
                reg1_raddr_o  = rs1;
                reg2_raddr_o  = rs2;
                dec.op1       = reg1_rdata_i;
                dec.op2       = reg2_rdata_i;
                dec.op1_jump  = inst_addr_i;
                dec.op2_jump  = imm_b;
                dec.is_branch = funct3[2:1] != 2'b01;
            end
            JAL: begin
                dec.reg_we   = 1'b1;
                dec.op1      = inst_addr_i;
                dec.op2      = 32'h4;
                dec.op1_jump = inst_addr_i;
                dec.op2_jump = imm_j;
                dec.is_jump  = 1'b1;
            end
            JALR: begin
                if (funct3 == 3'b000) begin
                    reg1_raddr_o = rs1;
                    dec.reg_we   = 1'b1;
                    dec.op1      = inst_addr_i;
                    dec.op2      = 32'h4;
                    dec.op1_jump = reg1_rdata_i;
                    dec.op2_jump = imm_i;
                    dec.is_jump  = 1'b1;
                end
            end
            LUI: begin
                dec.reg_we = 1'b1;
                dec.op1    = imm_u;
            end
            AUIPC: begin
                dec.reg_we = 1'b1;
                dec.op1    = inst_addr_i;
                dec.op2    = imm_u;
            end
            SYSTEM: begin
                if (funct3[1:0] != 2'b00) begin // ecall, ebreak and friends ignored
                    reg1_raddr_o  = funct3[2] ? '0 : rs1;
                    csr_raddr_o   = inst_i[31:20];
                    dec.csr_waddr = inst_i[31:20];
                    dec.reg_we    = 1'b1;
                    dec.csr_we    = 1'b1;
                    dec.csr_src   = funct3[2] ? {27'b0, rs1} : reg1_rdata_i; // zimm
                end
            end
            default: ; // load, store, fence
        endcase
    end

endmodule

// File: source/regs.sv
// general register file
// x0 reads zero, two asynchronous reads with write-through bypass
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module regs (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  rv_core_pkg::reg_addr_t  raddr1_i,
    input  rv_core_pkg::reg_addr_t  raddr2_i,
    output rv_core_pkg::word_t      rdata1_o,
    output rv_core_pkg::word_t      rdata2_o,
    wb_if.dst                       wb
);
    import rv_core_pkg::*;

    word_t regs_q [1:`RV_NUM_REGS-1];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < `RV_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb.reg_we && wb.reg_waddr != '0) begin
            regs_q[wb.reg_waddr] <= wb.reg_wdata;
        end
    end

    function automatic word_t rd_port(input reg_addr_t addr);
        if (addr == '0)
            rd_port = '0;
        else if (wb.reg_we && wb.reg_waddr == addr)
            rd_port = wb.reg_wdata; // forward the write-back
        else
            rd_port = regs_q[addr];
    endfunction

    assign rdata1_o = rd_port(raddr1_i);
    assign rdata2_o = rd_port(raddr2_i);

endmodule

// File: source/csr_file.sv
// machine CSR file
// mstatus, mtvec, mscratch and mepc; other addresses read zero
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module csr_file (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  rv_core_pkg::csr_addr_t  raddr_i,
    output rv_core_pkg::word_t      rdata_o,
    wb_if.dst                       wb
);
    import rv_core_pkg::*;

    word_t mstatus_q, mtvec_q, mscratch_q, mepc_q;
    logic  hit;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus_q  <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
        end else if (wb.csr_we) begin
            case (wb.csr_waddr)
                `RV_CSR_MSTATUS:  mstatus_q  <= wb.csr_wdata;
                `RV_CSR_MTVEC:    mtvec_q    <= wb.csr_wdata;
                `RV_CSR_MSCRATCH: mscratch_q <= wb.csr_wdata;
                `RV_CSR_MEPC:     mepc_q     <= wb.csr_wdata;
                default: ; // dropped
            endcase
        end
    end

    always_comb begin
        hit = 1'b1;
        case (raddr_i)
            `RV_CSR_MSTATUS:  rdata_o = mstatus_q;
            `RV_CSR_MTVEC:    rdata_o = mtvec_q;
            `RV_CSR_MSCRATCH: rdata_o = mscratch_q;
            `RV_CSR_MEPC:     rdata_o = mepc_q;
            default: begin
                rdata_o = '0;
                hit     = 1'b0;
            end
        endcase
        if (hit && wb.csr_we && wb.csr_waddr == raddr_i)
            rdata_o = wb.csr_wdata; // bypass
    end

endmodule

// File: source/ex.sv
// execute stage
// registers the decode bundle, runs the ALU, branch compare and CSR
// update, drives write-back and flush, and registers the retire ports
`timescale 1ns/1ps

module ex (
    input  logic                    clk_i,
    input  logic                    rst_i,
    id_ex_if.exe                    dec,
    wb_if.src                       wb,
    output logic                    flush_o,
    output logic                    retire_o,
    output rv_core_pkg::word_t      retire_addr_o,
    output logic                    rd_we_o,
    output rv_core_pkg::reg_addr_t  rd_addr_o,
    output rv_core_pkg::word_t      rd_data_o,
    output logic                    jump_o,
    output rv_core_pkg::word_t      jump_addr_o
);
    import rv_core_pkg::*;

    logic      valid_q, is_branch_q, is_jump_q, reg_we_q, csr_we_q;
    word_t     inst_addr_q, op1_q, op2_q, op1_jump_q, op2_jump_q, csr_rdata_q, csr_src_q;
    alu_op_e   alu_op_q;
    branch_e   branch_op_q;
    csr_op_e   csr_op_q;
    reg_addr_t reg_waddr_q;
    csr_addr_t csr_waddr_q;
    word_t     alu_res, csr_new, jump_addr;
    logic      cmp, taken;

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_o)
            valid_q <= 1'b0; // younger instruction squashed
        else
            valid_q <= dec.valid;
    end

    always_ff @(posedge clk_i) begin
        inst_addr_q <= dec.inst_addr;
        op1_q       <= dec.op1;
        op2_q       <= dec.op2;
        op1_jump_q  <= dec.op1_jump;
        op2_jump_q  <= dec.op2_jump;
        alu_op_q    <= dec.alu_op;
        is_branch_q <= dec.is_branch;
        branch_op_q <= dec.branch_op;
        is_jump_q   <= dec.is_jump;
        reg_we_q    <= dec.reg_we;
        reg_waddr_q <= dec.reg_waddr;
        csr_we_q    <= dec.csr_we;
        csr_waddr_q <= dec.csr_waddr;
        csr_rdata_q <= dec.csr_rdata;
        csr_op_q    <= dec.csr_op;
        csr_src_q   <= dec.csr_src;
    end

    always_comb begin
        case (alu_op_q)
            ALU_SUB:  alu_res = op1_q - op2_q;
            ALU_SLL:  alu_res = op1_q << op2_q[4:0];
            ALU_SLT:  alu_res = {31'b0, $signed(op1_q) < $signed(op2_q)};
            ALU_SLTU: alu_res = {31'b0, op1_q < op2_q};
            ALU_XOR:  alu_res = op1_q ^ op2_q;
            ALU_SRL:  alu_res = op1_q >> op2_q[4:0];
            ALU_SRA:  alu_res = word_t'($signed(op1_q) >>> op2_q[4:0]);
            ALU_OR:   alu_res = op1_q | op2_q;
            ALU_AND:  alu_res = op1_q & op2_q;
            default:  alu_res = op1_q + op2_q;
        endcase

        case (branch_op_q)
            BR_BEQ:  cmp = op1_q == op2_q;
            BR_BNE:  cmp = op1_q != op2_q;
            BR_BLT:  cmp = $signed(op1_q) < $signed(op2_q);
            BR_BGE:  cmp = $signed(op1_q) >= $signed(op2_q);
            BR_BLTU: cmp = op1_q < op2_q;
            default: cmp = op1_q >= op2_q;
        endcase

        case (csr_op_q)
            CSR_RS, CSR_RSI: csr_new = csr_rdata_q | csr_src_q;
            CSR_RC, CSR_RCI: csr_new = csr_rdata_q & ~csr_src_q;
            default:         csr_new = csr_src_q;
        endcase
    end

    assign taken     = valid_q && (is_jump_q || (is_branch_q && cmp));
    assign jump_addr = (op1_jump_q + op2_jump_q) & ~32'h1; // bit 0 only set for odd jalr sums
    assign flush_o   = taken;

    assign wb.reg_we    = valid_q && reg_we_q && reg_waddr_q != '0;
    assign wb.reg_waddr = reg_waddr_q;
    assign wb.reg_wdata = csr_we_q ? csr_rdata_q : alu_res; // csr ops return old value
    assign wb.csr_we    = valid_q && csr_we_q;
    assign wb.csr_waddr = csr_waddr_q;
    assign wb.csr_wdata = csr_new;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            retire_o <= 1'b0;
            rd_we_o  <= 1'b0;
            jump_o   <= 1'b0;
        end else begin
            retire_o <= valid_q;
            rd_we_o  <= wb.reg_we;
            jump_o   <= taken;
        end
    end

    always_ff @(posedge clk_i) begin
        retire_addr_o <= inst_addr_q;
        rd_addr_o     <= reg_waddr_q;
        rd_data_o     <= wb.reg_wdata;
        jump_addr_o   <= jump_addr;
    end

endmodule

// File: source/rv_core_top.sv
// rv core top
// three stage pipeline: fetch register, decode, execute with write-back
`timescale 1ns/1ps

module rv_core_top (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  rv_core_pkg::inst_t      inst_i,
    input  rv_core_pkg::word_t      inst_addr_i,
    input  logic                    inst_valid_i,
    output logic                    retire_o,
    output rv_core_pkg::word_t      retire_addr_o,
    output logic                    rd_we_o,
    output rv_core_pkg::reg_addr_t  rd_addr_o,
    output rv_core_pkg::word_t      rd_data_o,
    output logic                    jump_o,
    output rv_core_pkg::word_t      jump_addr_o
);
    import rv_core_pkg::*;

    inst_t     id_inst;
    word_t     id_inst_addr, reg1_rdata, reg2_rdata, csr_rdata;
    logic      id_valid, flush;
    reg_addr_t reg1_raddr, reg2_raddr;
    csr_addr_t csr_raddr;

    id_ex_if id_ex ();
    wb_if    wb ();

    if_id u_if_id (
        .clk_i, .rst_i, .flush_i(flush), .inst_i, .inst_addr_i, .inst_valid_i,
        .inst_o(id_inst), .inst_addr_o(id_inst_addr), .valid_o(id_valid)
    );

    id u_id (
        .inst_i(id_inst), .inst_addr_i(id_inst_addr), .valid_i(id_valid),
        .reg1_raddr_o(reg1_raddr), .reg2_raddr_o(reg2_raddr),
        .reg1_rdata_i(reg1_rdata), .reg2_rdata_i(reg2_rdata),
        .csr_raddr_o(csr_raddr), .csr_rdata_i(csr_rdata), .dec(id_ex.dec)
    );

    regs u_regs (
        .clk_i, .rst_i, .raddr1_i(reg1_raddr), .raddr2_i(reg2_raddr),
        .rdata1_o(reg1_rdata), .rdata2_o(reg2_rdata), .wb(wb.dst)
    );

    csr_file u_csr_file (
        .clk_i, .rst_i, .raddr_i(csr_raddr), .rdata_o(csr_rdata), .wb(wb.dst)
    );

    ex u_ex (
        .clk_i, .rst_i, .dec(id_ex.exe), .wb(wb.src), .flush_o(flush),
        .retire_o, .retire_addr_o, .rd_we_o, .rd_addr_o, .rd_data_o, .jump_o, .jump_addr_o
    );

endmodule

// File: dv/rv_core_chk.sv
// rv core checker
// concurrent assertions on the retire ports, bound to the top level
`timescale 1ns/1ps

module rv_core_chk (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    retire_i,
    input rv_core_pkg::word_t      retire_addr_i,
    input logic                    rd_we_i,
    input rv_core_pkg::reg_addr_t  rd_addr_i,
    input rv_core_pkg::word_t      rd_data_i,
    input logic                    jump_i
);
    int fail_cnt = 0;

    quiet_in_reset: assert property (@(posedge clk_i) rst_i |=> !retire_i && !rd_we_i && !jump_i)
        else begin
            $error("retirement, write or jump while reset is active");
            fail_cnt++;
        end

    jump_retires: assert property (@(posedge clk_i) disable iff (rst_i) jump_i |-> retire_i)
        else begin
            $error("jump reported without a retirement");
            fail_cnt++;
        end

    x0_stays_zero: assert property (@(posedge clk_i) disable iff (rst_i)
        rd_we_i |-> (rd_addr_i != '0 || rd_data_i == '0))
        else begin
            $error("nonzero write to x0");
            fail_cnt++;
        end

    no_double_retire: assert property (@(posedge clk_i) disable iff (rst_i)
        retire_i && $past(retire_i) |-> retire_addr_i != $past(retire_addr_i))
        else begin
            $error("same address retired in two consecutive cycles");
            fail_cnt++;
        end

endmodule

// File: dv/rv_core_scoreboard.sv
// rv core scoreboard
// architectural model of registers and CSRs, expected retire queue,
// compares every retire slot three cycles after the instruction was presented
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_scoreboard (
    input logic                    clk_i,
    input logic                    rst_i,
    input rv_core_pkg::inst_t      inst_i,
    input rv_core_pkg::word_t      inst_addr_i,
    input logic                    inst_valid_i,
    input logic                    retire_i,
    input rv_core_pkg::word_t      retire_addr_i,
    input logic                    rd_we_i,
    input rv_core_pkg::reg_addr_t  rd_addr_i,
    input rv_core_pkg::word_t      rd_data_i,
    input logic                    jump_i,
    input rv_core_pkg::word_t      jump_addr_i
);
    import rv_core_pkg::*;

    typedef struct packed {
        logic      retire;
        word_t     addr;
        logic      rd_we;
        reg_addr_t rd;
        word_t     data;
        logic      jump;
        word_t     target;
    } exp_t;

    word_t x_m [32];
    word_t csr_m [4];
    exp_t  exp_q [$];
    int    squash = 0; // slots still to discard after a taken jump
    int    err_cnt = 0;
    int    chk_cnt = 0;

    function automatic int csr_slot(input csr_addr_t a);
        case (a)
            `RV_CSR_MSTATUS:  return 0;
            `RV_CSR_MTVEC:    return 1;
            `RV_CSR_MSCRATCH: return 2;
            `RV_CSR_MEPC:     return 3;
            default:          return -1;
        endcase
    endfunction

    function automatic word_t alu(input logic [2:0] f3, input logic alt, input word_t a,
                                  input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt)
                    return $signed(a) >>> b[4:0];
                else
                    return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // reference model, one instruction in program order
    function automatic exp_t apply_inst(input inst_t in, input word_t pc);
        exp_t       e;
        word_t      a, b, imm_i, imm_b, imm_j, imm_u, old, src, wval;
        logic [2:0] f3;
        logic       wr;
        int         slot;
        f3    = in[14:12];
        a     = x_m[in[19:15]];
        b     = x_m[in[24:20]];
        imm_i = {{20{in[31]}}, in[31:20]};
        imm_b = {{20{in[31]}}, in[7], in[30:25], in[11:8], 1'b0};
        imm_j = {{12{in[31]}}, in[19:12], in[20], in[30:21], 1'b0};
        imm_u = {in[31:12], 12'b0};
        e        = '0;
        e.retire = 1'b1;
        e.addr   = pc;
        e.rd     = in[11:7];
        wr       = 1'b0;
        wval     = '0;
        case (in[6:0])
            OP_IMM: begin
                wr   = 1'b1;
                wval = alu(f3, f3 == 3'b101 && in[30], a, imm_i);
            end
            OP: begin
                if (in[31:25] == 7'b0000000 || in[31:25] == 7'b0100000) begin
                    wr   = 1'b1;
                    wval = alu(f3, in[30], a, b);
                end
            end
            LUI: begin
                wr   = 1'b1;
                wval = imm_u;
            end
            AUIPC: begin
                wr   = 1'b1;
                wval = pc + imm_u;
            end
            JAL: begin
                wr       = 1'b1;
                wval     = pc + 4;
                e.jump   = 1'b1;
                e.target = pc + imm_j;
            end
            JALR: begin
                if (f3 == 3'b000) begin
                    wr       = 1'b1;
                    wval     = pc + 4;
                    e.jump   = 1'b1;
                    e.target = (a + imm_i) & ~32'h1;
                end
            end
            BRANCH: begin
                e.target = pc + imm_b;
                case (f3)
                    3'b000:  e.jump = a == b;
                    3'b001:  e.jump = a != b;
                    3'b100:  e.jump = $signed(a) < $signed(b);
                    3'b101:  e.jump = $signed(a) >= $signed(b);
                    3'b110:  e.jump = a < b;
                    3'b111:  e.jump = a >= b;
                    default: e.jump = 1'b0;
                endcase
            end
            SYSTEM: begin
                if (f3[1:0] != 2'b00) begin
                    slot = csr_slot(in[31:20]);
                    old  = (slot >= 0) ? csr_m[slot] : '0;
                    src  = f3[2] ? {27'b0, in[19:15]} : a;
                    if (slot >= 0)
                        csr_m[slot] = (f3[1:0] == 2'b01) ? src :
                                      (f3[1:0] == 2'b10) ? (old | src) : (old & ~src);
                    wr   = 1'b1;
                    wval = old;
                end
            end
            default: ; // load, store, fence
        endcase
        if (wr && in[11:7] != 5'd0) begin
            x_m[in[11:7]] = wval;
            e.rd_we       = 1'b1;
            e.data        = wval;
        end
        return e;
    endfunction

    task automatic report(input string what, input word_t got, input word_t exp, input word_t pc);
        err_cnt++;
        $display("[FAIL] %0t: %s for inst at %h, got %h expected %h", $time, what, pc, got, exp);
    endtask

    task automatic compare(input exp_t e);
        chk_cnt++;
        if (retire_i !== e.retire)
            report("retire_o", {31'b0, retire_i}, {31'b0, e.retire}, e.addr);
        if (e.retire && retire_addr_i !== e.addr)
            report("retire_addr_o", retire_addr_i, e.addr, e.addr);
        if (rd_we_i !== e.rd_we)
            report("rd_we_o", {31'b0, rd_we_i}, {31'b0, e.rd_we}, e.addr);
        if (e.rd_we && rd_addr_i !== e.rd)
            report("rd_addr_o", {27'b0, rd_addr_i}, {27'b0, e.rd}, e.addr);
        if (e.rd_we && rd_data_i !== e.data)
            report("rd_data_o", rd_data_i, e.data, e.addr);
        if (jump_i !== e.jump)
            report("jump_o", {31'b0, jump_i}, {31'b0, e.jump}, e.addr);
        if (e.jump && jump_addr_i !== e.target)
            report("jump_addr_o", jump_addr_i, e.target, e.addr);
    endtask

    always @(posedge clk_i) begin
        exp_t nxt;
        if (exp_q.size() == 3)
            compare(exp_q.pop_front());
        nxt = '0;
        if (rst_i) begin
            foreach (x_m[i]) x_m[i] = '0;
            foreach (csr_m[i]) csr_m[i] = '0;
            squash = 0;
        end else if (squash > 0) begin
            squash--; // slot flushed by an older jump
        end else if (inst_valid_i) begin
            nxt = apply_inst(inst_i, inst_addr_i);
            if (nxt.jump)
                squash = 2;
        end
        exp_q.push_back(nxt);
    end

endmodule

// File: dv/rv_core_tb.sv
// rv core testbench
// clock, reset, seeded random instruction stream and run control
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_tb;
    import rv_core_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int N_ALU        = 300;
    localparam int N_JUMP       = 120;
    localparam int N_BRANCH     = 160;
    localparam int N_CSR        = 120;
    localparam int N_MISC       = 60;
    localparam int N_MIXED      = 400;
    localparam int STIM_CYCLES  = N_ALU + N_JUMP + N_BRANCH + N_CSR + N_MISC + N_MIXED;
    localparam int DRAIN_CYCLES = 10;

    logic      clk = 1'b0;
    logic      rst, inst_valid, retire, rd_we, jump;
    inst_t     inst;
    word_t     inst_addr, retire_addr, rd_data, jump_addr, pc;
    reg_addr_t rd_addr;
    integer    seed;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rv_core_top DUT (
        .clk_i(clk), .rst_i(rst), .inst_i(inst), .inst_addr_i(inst_addr),
        .inst_valid_i(inst_valid), .retire_o(retire), .retire_addr_o(retire_addr),
        .rd_we_o(rd_we), .rd_addr_o(rd_addr), .rd_data_o(rd_data), .jump_o(jump),
        .jump_addr_o(jump_addr)
    );

    rv_core_scoreboard u_scoreboard (
        .clk_i(clk), .rst_i(rst), .inst_i(inst), .inst_addr_i(inst_addr),
        .inst_valid_i(inst_valid), .retire_i(retire), .retire_addr_i(retire_addr),
        .rd_we_i(rd_we), .rd_addr_i(rd_addr), .rd_data_i(rd_data), .jump_i(jump),
        .jump_addr_i(jump_addr)
    );

    bind rv_core_top rv_core_chk u_chk (
        .clk_i(clk_i), .rst_i(rst_i), .retire_i(retire_o), .retire_addr_i(retire_addr_o),
        .rd_we_i(rd_we_o), .rd_addr_i(rd_addr_o), .rd_data_i(rd_data_o), .jump_i(jump_o)
    );

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // kind 0 op-imm, 1 op, 2 lui, 3 auipc, 4 jal, 5 jalr, 6 branch, 7 csr, others no effect
    function automatic inst_t rand_inst(input int kind);
        logic [31:0] r, s;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] csr;
        r   = $random(seed);
        s   = $random(seed);
        rd  = {2'b0, r[2:0]}; // x0..x7 keeps dependencies dense
        rs1 = {2'b0, r[5:3]};
        rs2 = r[13] ? rs1 : {2'b0, r[8:6]};
        f3  = r[11:9];
        f7  = (r[12] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
        case (s[21:20])
            2'd0:    csr = `RV_CSR_MSTATUS;
            2'd1:    csr = `RV_CSR_MTVEC;
            2'd2:    csr = `RV_CSR_MSCRATCH;
            default: csr = `RV_CSR_MEPC;
        endcase
        if (s[23:22] == 2'b11)
            csr = 12'h7c0; // unimplemented
        case (kind)
            0: begin
                if (f3[1:0] == 2'b01)
                    return {f7, s[4:0], rs1, f3, rd, OP_IMM}; // shifts
                else
                    return {s[11:0], rs1, f3, rd, OP_IMM};
            end
            1: return {f7, rs2, rs1, f3, rd, OP};
            2: return {s[31:12], rd, LUI};
            3: return {s[31:12], rd, AUIPC};
            4: return {s[31:12], rd, JAL};
            5: return {s[31:20], rs1, 3'b000, rd, JALR};
            6: return {s[31:25], rs2, rs1, f3, s[11:7], BRANCH};
            7: begin
                if (f3[1:0] == 2'b00)
                    f3[1:0] = 2'b01;
                return {csr, f3[2] ? s[19:15] : rs1, f3, rd, SYSTEM};
            end
            default: begin
                case (s[1:0])
                    2'd0:    return {s[31:7], LOAD};
                    2'd1:    return {s[31:7], STORE};
                    2'd2:    return {7'b0000001, rs2, rs1, f3, rd, OP}; // M ext
                    default: return {s[31:7], FENCE};
                endcase
            end
        endcase
    endfunction

    task automatic issue(input inst_t i);
        @(posedge clk);
        inst       <= i;
        inst_addr  <= pc;
        inst_valid <= 1'b1;
        pc = pc + 4;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        inst       <= $random(seed); // must be ignored
        inst_valid <= 1'b0;
    endtask

    // one cycle per iteration with a third of the slots on plain ALU work
    task automatic run_phase(input int n, input int lo, input int span, input bit gaps);
        for (int i = 0; i < n; i++) begin
            if (gaps && pick(4) == 0)
                idle_cycle();
            else if (pick(3) == 0)
                issue(rand_inst(pick(2)));
            else
                issue(rand_inst(lo + pick(span)));
        end
    endtask

    initial begin
        rst        = 1'b1;
        inst       = '0;
        inst_addr  = '0;
        inst_valid = 1'b0;
        seed       = 89;
        pc         = `RV_RESET_ADDR;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        run_phase(N_ALU, 0, 2, 1'b0);
        run_phase(N_JUMP, 2, 4, 1'b0);
        run_phase(N_BRANCH, 6, 1, 1'b0);
        run_phase(N_CSR, 7, 1, 1'b0);
        run_phase(N_MISC, 8, 1, 1'b0);
        run_phase(N_MIXED, 0, 9, 1'b1);
        @(posedge clk);
        inst_valid <= 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);
        @(negedge clk); // counters settled after the last compare edge
        $display("checked %0d retire slots, %0d compare errors, %0d assertion errors",
                 u_scoreboard.chk_cnt, u_scoreboard.err_cnt, DUT.u_chk.fail_cnt);
        if (u_scoreboard.err_cnt == 0 && DUT.u_chk.fail_cnt == 0 && u_scoreboard.chk_cnt > 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial begin
        #((RESET_CYCLES + STIM_CYCLES + DRAIN_CYCLES + 50) * CLK_PERIOD);
        $display("watchdog expired before the stimulus finished");
        $display("Test failures found");
        $finish;
    end

endmodule

// File: sources.f
+incdir+common
common/rv_core_pkg.sv
common/pipe_if.sv
decode/if_id.sv
decode/id.sv
source/regs.sv
source/csr_file.sv
source/ex.sv
source/rv_core_top.sv
dv/rv_core_chk.sv
dv/rv_core_scoreboard.sv
dv/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - common
    files:
      - common/rv_core_pkg.sv
      - common/pipe_if.sv
      - decode/if_id.sv
      - decode/id.sv
      - source/regs.sv
      - source/csr_file.sv
      - source/ex.sv
      - source/rv_core_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/rv_core_chk.sv
      - dv/rv_core_scoreboard.sv
      - dv/rv_core_tb.sv
